/* compile.f */
common/fetch_pkg.sv
predictor/gshare_pht.sv
predictor/branch_target_buffer.sv
logic/resolve_queue.sv
logic/fetch_ctrl.sv
logic/fetch_top.sv
verification/fetch_props.sv
verification/fetch_tb.sv

/* Makefile */
TOP = fetch_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* verification/fetch_tb.sv */
`timescale 1ns/10ps

module fetch_tb
    import fetch_pkg::*;
();

    localparam int N_RESOLVES  = 2000;
    localparam int CYCLE_LIMIT = N_RESOLVES * 40;
    localparam int MEM_WORDS   = 1024;

    logic               clk_g = 1'b0;
    logic               rst_i;
    logic               wb_cyc_o;
    logic               wb_stb_o;
    logic [PC_W-1:0]    wb_adr_o;
    logic [INSTR_W-1:0] wb_dat_i;
    logic               wb_ack_i;
    fetch_out_t         out_o;
    logic               out_valid_o;
    logic               out_ready_i;
    resolve_t           res_i;
    logic               res_valid_i;

    // reference model of memory, predictors and the unresolved list
    logic [31:0]         lfsr = 32'hcd38;
    logic [31:0]         mem [MEM_WORDS];
    logic [1:0]          m_ctr [TBL_SIZE];
    logic [HIST_W-1:0]   m_hist = '0;
    logic [TBL_SIZE-1:0] m_btb_valid = '0;
    logic [TAG_W-1:0]    m_btb_tag [TBL_SIZE];
    logic [PC_W-1:0]     m_btb_tgt [TBL_SIZE];
    fetch_out_t          m_rq [$];
    fetch_out_t          m_out = '0;
    logic                m_out_hit = 1'b0;
    logic                m_out_valid = 1'b0;
    pred_t               m_bus_pred = '0;
    logic                m_bus_hit = 1'b0;
    logic [PC_W-1:0]     m_bus_pc = '0;
    logic                m_discard = 1'b0;
    logic [PC_W-1:0]     exp_pc = RESET_PC;
    logic [1:0]          wait_left = '0;
    logic                prev_cyc = 1'b0;
    logic                prev_ack = 1'b0;
    logic                prev_ready = 1'b1;
    int                  resolves = 0;
    int                  cycles = 0;
    int                  taken_seen = 0;

    fetch_top dut0 (.*);

    always #10 clk_g = ~clk_g;

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // eight branch targets with distinct table slots
    function automatic logic [PC_W-1:0] target_addr(input logic [2:0] sel);
        return 32'h0000_0040 + 32'(sel) * 32'h0000_00c4;
    endfunction

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic require(input bit ok, input string what);
        assert (ok) else begin
            $display("Error at %0t: %s", $time, what);
            abort_run();
        end
    endtask

    // gshare index and btb hit seen when a bus cycle starts
    task automatic predict_lookup(input logic [PC_W-1:0] pc, output pred_t p, output logic hit);
        logic [IDX_W-1:0] slot;
        slot     = pc[6:2];
        hit      = m_btb_valid[slot] && (m_btb_tag[slot] == pc[31:7]);
        p.index  = slot ^ m_hist;
        p.taken  = m_ctr[p.index][1] && hit;
        p.target = m_btb_tgt[slot];
    endtask

    // pop the oldest, train, and report a mispredict with its corrected pc
    task automatic resolve_oldest(input resolve_t r, output logic flush,
                                  output logic [PC_W-1:0] corr);
        fetch_out_t head;
        head  = m_rq.pop_front();
        flush = (r.branch && (head.pred.taken != r.taken)) ||
                (r.branch && r.taken && head.pred.taken && (head.pred.target != r.target)) ||
                (!r.branch && head.pred.taken);
        corr  = r.taken ? r.target : head.pc + 32'd4;
        if (r.branch) begin
            if (r.taken && m_ctr[head.pred.index] != 2'b11) begin
                m_ctr[head.pred.index] = m_ctr[head.pred.index] + 2'b01;
            end else if (!r.taken && m_ctr[head.pred.index] != 2'b00) begin
                m_ctr[head.pred.index] = m_ctr[head.pred.index] - 2'b01;
            end
            m_hist = {m_hist[HIST_W-2:0], r.taken};
            if (r.taken) begin
                m_btb_valid[head.pc[6:2]] = 1'b1;
                m_btb_tag[head.pc[6:2]]   = head.pc[31:7];
                m_btb_tgt[head.pc[6:2]]   = r.target;
            end
        end
        resolves++;
    endtask

    always @(posedge clk_g) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Error: run hung, %0d resolves after %0d cycles", resolves, cycles);
            abort_run();
        end
    end

    initial begin
        resolve_t        res;
        logic            ready;
        logic            ack;
        logic            do_res;
        logic            transfer;
        logic            flush;
        logic [PC_W-1:0] corr;
        rst_i       = 1'b1;
        wb_dat_i    = '0;
        wb_ack_i    = 1'b0;
        out_ready_i = 1'b1;
        res_i       = '0;
        res_valid_i = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = rand_bits(32);
        end
        for (int i = 0; i < TBL_SIZE; i++) begin
            m_ctr[i]     = 2'b01;
            m_btb_tag[i] = '0;
            m_btb_tgt[i] = '0;
        end
        repeat (10) @(posedge clk_g);
        #1;
        expect_equal("wb_cyc_o", 32'(wb_cyc_o), 32'd0);
        expect_equal("out_valid_o", 32'(out_valid_o), 32'd0);
        rst_i = 1'b0;

        while (resolves < N_RESOLVES) begin
            @(posedge clk_g);
            #1;
            expect_equal("wb_stb_o", 32'(wb_stb_o), 32'(wb_cyc_o));
            expect_equal("out_valid_o", 32'(out_valid_o), 32'(m_out_valid));
            // a bus cycle ends right after its ack
            if (prev_ack) begin
                expect_equal("wb_cyc_o", 32'(wb_cyc_o), 32'd0);
            end
            if (wb_cyc_o && !prev_cyc) begin
                require(prev_ready && (m_rq.size() < RQ_DEPTH), "bus cycle started while stalled");
                expect_equal("wb_adr_o", wb_adr_o, exp_pc);
                require(wb_adr_o < 4 * MEM_WORDS, "fetch address outside the memory");
                predict_lookup(wb_adr_o, m_bus_pred, m_bus_hit);
                m_bus_pc  = wb_adr_o;
                m_discard = 1'b0;
                wait_left = 2'(rand_bits(2));
            end
            // slave acks once its wait states have run out
            ack = 1'b0;
            if (wb_cyc_o) begin
                if (wait_left == 2'd0) begin
                    ack = 1'b1;
                end else begin
                    wait_left = wait_left - 2'd1;
                end
            end
            ready      = (rand_bits(2) != 0);
            do_res     = (rand_bits(2) == 3) && (m_rq.size() != 0);
            res.branch = (rand_bits(1) != 0);
            res.taken  = res.branch && (rand_bits(1) != 0);
            res.target = target_addr(3'(rand_bits(3)));

            wb_ack_i    = ack;
            wb_dat_i    = ack ? mem[wb_adr_o[11:2]] : '0;
            out_ready_i = ready;
            res_i       = res;
            res_valid_i = do_res;

            // what the coming edge does
            transfer = out_valid_o && ready;
            if (transfer) begin
                expect_equal("out_o.pc", out_o.pc, m_out.pc);
                expect_equal("out_o.instr", out_o.instr, m_out.instr);
                expect_equal("out_o.pred.taken", 32'(out_o.pred.taken), 32'(m_out.pred.taken));
                expect_equal("out_o.pred.index", 32'(out_o.pred.index), 32'(m_out.pred.index));
                if (m_out_hit) begin
                    expect_equal("out_o.pred.target", out_o.pred.target, m_out.pred.target);
                end
                if (m_out.pred.taken) begin
                    taken_seen++;
                end
            end
            flush = 1'b0;
            corr  = '0;
            if (do_res) begin
                resolve_oldest(res, flush, corr);
            end
            if (transfer && !flush) begin
                m_rq.push_back(m_out);
            end
            if (transfer) begin
                m_out_valid = 1'b0;
            end
            if (flush) begin
                // wrong path gone and an open access drains unseen
                m_rq.delete();
                m_out_valid = 1'b0;
                exp_pc      = corr;
                if (wb_cyc_o && !ack) begin
                    m_discard = 1'b1;
                end
            end else if (wb_cyc_o && ack && !m_discard) begin
                m_out.pc    = m_bus_pc;
                m_out.instr = mem[m_bus_pc[11:2]];
                m_out.pred  = m_bus_pred;
                m_out_hit   = m_bus_hit;
                m_out_valid = 1'b1;
                exp_pc      = m_bus_pred.taken ? m_bus_pred.target : m_bus_pc + 32'd4;
            end
            prev_cyc   = wb_cyc_o;
            prev_ack   = ack;
            prev_ready = ready;
        end

        if (taken_seen > 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Error: no taken prediction ever reached decode");
            abort_run();
        end
    end

endmodule

/* verification/fetch_props.sv */
`timescale 1ns/10ps

module fetch_props
    import fetch_pkg::*;
(
    input logic            clk_g,
    input logic            rst_i,
    input logic            wb_stb_o,
    input logic [PC_W-1:0] wb_adr_o,
    input logic            wb_ack_i,
    input fetch_out_t      out_o,
    input logic            out_valid_o,
    input logic            out_ready_i,
    input redirect_t       redirect_i
);

    // strobe and address hold until the slave acks
    a_stb_hold: assert property (@(posedge clk_g) disable iff (rst_i)
        wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o))
        else $error("wishbone strobe or address changed before ack");

    // only a flush may take away a waiting instruction
    a_out_hold: assert property (@(posedge clk_g) disable iff (rst_i)
        out_valid_o && !out_ready_i && !redirect_i.valid |=> out_valid_o && $stable(out_o))
        else $error("decode output changed while stalled");

    // restart needs a fresh bus cycle before anything reaches decode
    a_redirect_drop: assert property (@(posedge clk_g) disable iff (rst_i)
        redirect_i.valid || $past(redirect_i.valid) |=> !out_valid_o)
        else $error("instruction offered within two cycles of a redirect");

endmodule

bind fetch_ctrl fetch_props u_props (
    .clk_g       (clk_g),
    .rst_i       (rst_i),
    .wb_stb_o    (wb_stb_o),
    .wb_adr_o    (wb_adr_o),
    .wb_ack_i    (wb_ack_i),
    .out_o       (out_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .redirect_i  (redirect_i)
);

/* logic/fetch_top.sv */
`timescale 1ns/10ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic               clk_g,
    input  logic               rst_i,
    output logic               wb_cyc_o,
    output logic               wb_stb_o,
    output logic [PC_W-1:0]    wb_adr_o,
    input  logic [INSTR_W-1:0] wb_dat_i,
    input  logic               wb_ack_i,
    output fetch_out_t         out_o,
    output logic               out_valid_o,
    input  logic               out_ready_i,
    input  resolve_t           res_i,
    input  logic               res_valid_i
);

    logic [PC_W-1:0]  lookup_pc;
    logic             pht_taken;
    logic [IDX_W-1:0] pht_index;
    logic             btb_hit;
    logic [PC_W-1:0]  btb_target;
    logic             push;
    fetch_out_t       push_data;
    logic             queue_full;
    train_t           train;
    logic             train_branch;
    redirect_t        redirect;

    fetch_ctrl u_ctrl (
        .clk_g        (clk_g),
        .rst_i        (rst_i),
        .wb_cyc_o     (wb_cyc_o),
        .wb_stb_o     (wb_stb_o),
        .wb_adr_o     (wb_adr_o),
        .wb_dat_i     (wb_dat_i),
        .wb_ack_i     (wb_ack_i),
        .out_o        (out_o),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .lookup_pc_o  (lookup_pc),
        .pht_taken_i  (pht_taken),
        .pht_index_i  (pht_index),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .push_o       (push),
        .push_data_o  (push_data),
        .queue_full_i (queue_full),
        .redirect_i   (redirect)
    );

    gshare_pht u_pht (
        .clk_g          (clk_g),
        .rst_i          (rst_i),
        .lookup_pc_i    (lookup_pc),
        .taken_o        (pht_taken),
        .index_o        (pht_index),
        .train_i        (train),
        .train_branch_i (train_branch)
    );

    branch_target_buffer u_btb (
        .clk_g       (clk_g),
        .rst_i       (rst_i),
        .lookup_pc_i (lookup_pc),
        .hit_o       (btb_hit),
        .target_o    (btb_target),
        .train_i     (train)
    );

    resolve_queue u_rq (
        .clk_g          (clk_g),
        .rst_i          (rst_i),
        .push_i         (push),
        .push_data_i    (push_data),
        .full_o         (queue_full),
        .res_i          (res_i),
        .res_valid_i    (res_valid_i),
        .train_o        (train),
        .train_branch_o (train_branch),
        .redirect_o     (redirect)
    );

endmodule

/* logic/fetch_ctrl.sv */
`timescale 1ns/10ps

module fetch_ctrl
    import fetch_pkg::*;
(
    input  logic               clk_g,
    input  logic               rst_i,
    // wishbone classic read master
    output logic               wb_cyc_o,
    output logic               wb_stb_o,
    output logic [PC_W-1:0]    wb_adr_o,
    input  logic [INSTR_W-1:0] wb_dat_i,
    input  logic               wb_ack_i,
    // decode
    output fetch_out_t         out_o,
    output logic               out_valid_o,
    input  logic               out_ready_i,
    // predictor lookup
    output logic [PC_W-1:0]    lookup_pc_o,
    input  logic               pht_taken_i,
    input  logic [IDX_W-1:0]   pht_index_i,
    input  logic               btb_hit_i,
    input  logic [PC_W-1:0]    btb_target_i,
    // resolve queue
    output logic               push_o,
    output fetch_out_t         push_data_o,
    input  logic               queue_full_i,
    input  redirect_t          redirect_i
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUS,
        S_DELIVER,
        S_DISCARD
    } state_t;

    state_t          state_q;
    logic [PC_W-1:0] fetch_pc_q;
    logic [PC_W-1:0] restart_pc_q;
    logic            bus_first_q;
    pred_t           pred_q;
    fetch_out_t      out_q;
    logic            out_valid_q;

    pred_t pred_now;
    pred_t pred_bus;
    logic  transfer;
    logic  can_start;

    // lookup always follows the address of the next or current bus cycle
    assign lookup_pc_o = fetch_pc_q;

    assign pred_now.taken  = pht_taken_i & btb_hit_i;
    assign pred_now.target = btb_target_i;
    assign pred_now.index  = pht_index_i;

    // the prediction belongs to the first cycle of the bus access
    assign pred_bus = bus_first_q ? pred_now : pred_q;

    assign transfer  = out_valid_q & out_ready_i;
    assign can_start = out_ready_i & ~queue_full_i;

    assign wb_cyc_o = (state_q == S_BUS) || (state_q == S_DISCARD);
    assign wb_stb_o = wb_cyc_o;
    assign wb_adr_o = fetch_pc_q;

    assign out_o       = out_q;
    assign out_valid_o = out_valid_q;
    assign push_o      = transfer;
    assign push_data_o = out_q;

    always_ff @(posedge clk_g) begin
        if (rst_i) begin
            state_q     <= S_IDLE;
            fetch_pc_q  <= RESET_PC;
            bus_first_q <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            bus_first_q <= 1'b0;
            if (redirect_i.valid) begin
                out_valid_q <= 1'b0;
                // an open bus cycle must finish before the new address goes out
                if (wb_cyc_o && !wb_ack_i) begin
                    state_q <= S_DISCARD;
                end else begin
                    state_q    <= S_IDLE;
                    fetch_pc_q <= redirect_i.pc;
                end
            end else begin
                case (state_q)
                    S_IDLE: begin
                        if (can_start) begin
                            state_q     <= S_BUS;
                            bus_first_q <= 1'b1;
                        end
                    end
                    S_BUS: begin
                        if (wb_ack_i) begin
                            state_q     <= S_DELIVER;
                            out_valid_q <= 1'b1;
                            fetch_pc_q  <= pred_bus.taken ? pred_bus.target
                                                          : fetch_pc_q + PC_W'(4);
                        end
                    end
                    S_DELIVER: begin
                        if (transfer) begin
                            out_valid_q <= 1'b0;
                            // queue_full_i already counts this push
                            if (!queue_full_i) begin
                                state_q     <= S_BUS;
                                bus_first_q <= 1'b1;
                            end else begin
                                state_q <= S_IDLE;
                            end
                        end
                    end
                    S_DISCARD: begin
                        if (wb_ack_i) begin
                            state_q    <= S_IDLE;
                            fetch_pc_q <= restart_pc_q;
                        end
                    end
                    default: state_q <= S_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk_g) begin
        if (state_q == S_BUS && bus_first_q) begin
            pred_q <= pred_now;
        end
        if (state_q == S_BUS && wb_ack_i) begin
            out_q.pc    <= fetch_pc_q;
            out_q.instr <= wb_dat_i;
            out_q.pred  <= pred_bus;
        end
        // corrected pc waits here while a stale access drains
        if (redirect_i.valid) begin
            restart_pc_q <= redirect_i.pc;
        end
    end

endmodule

/* logic/resolve_queue.sv */
`timescale 1ns/10ps

module resolve_queue
    import fetch_pkg::*;
(
    input  logic       clk_g,
    input  logic       rst_i,
    input  logic       push_i,
    input  fetch_out_t push_data_i,
    output logic       full_o,
    input  resolve_t   res_i,
    input  logic       res_valid_i,
    output train_t     train_o,
    output logic       train_branch_o,
    output redirect_t  redirect_o
);

    logic [PC_W-1:0] pc_mem   [RQ_DEPTH];
    pred_t           pred_mem [RQ_DEPTH];

    logic [RQ_PTR_W-1:0] head_q;
    logic [RQ_PTR_W-1:0] tail_q;
    logic [RQ_PTR_W:0]   count_q;
    logic [RQ_PTR_W:0]   count_next;

    logic [PC_W-1:0] head_pc;
    pred_t           head_pred;
    logic            dir_wrong;
    logic            tgt_wrong;
    logic            nonbr_wrong;
    logic            mispredict;
    logic            flush;

    assign head_pc   = pc_mem[head_q];
    assign head_pred = pred_mem[head_q];

    // compare the oldest prediction against what execute saw
    assign dir_wrong   = res_i.branch && (head_pred.taken != res_i.taken);
    assign tgt_wrong   = res_i.branch && res_i.taken && head_pred.taken &&
                         (head_pred.target != res_i.target);
    assign nonbr_wrong = !res_i.branch && head_pred.taken;
    assign mispredict  = dir_wrong | tgt_wrong | nonbr_wrong;
    assign flush       = res_valid_i & mispredict;

    assign redirect_o.valid = flush;
    assign redirect_o.pc    = res_i.taken ? res_i.target : head_pc + PC_W'(4);

    // every resolve is reported, the predictors pick what they need
    assign train_o.valid   = res_valid_i;
    assign train_o.pc      = head_pc;
    assign train_o.taken   = res_i.branch & res_i.taken;
    assign train_o.target  = res_i.target;
    assign train_o.index   = head_pred.index;
    assign train_branch_o  = res_valid_i & res_i.branch;

    // occupancy after this edge, so fetch can decide whether to start the next bus cycle
    always_comb begin
        if (flush) begin
            count_next = '0;
        end else begin
            count_next = count_q + (RQ_PTR_W+1)'(push_i) - (RQ_PTR_W+1)'(res_valid_i);
        end
    end

    assign full_o = (count_next == (RQ_PTR_W+1)'(RQ_DEPTH));

    always_ff @(posedge clk_g) begin
        if (rst_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush) begin
            // younger entries are wrong path, including one pushed now
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (res_valid_i) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_next;
        end
    end

    always_ff @(posedge clk_g) begin
        if (push_i) begin
            pc_mem[tail_q]   <= push_data_i.pc;
            pred_mem[tail_q] <= push_data_i.pred;
        end
    end

endmodule

/* predictor/branch_target_buffer.sv */
`timescale 1ns/10ps

module branch_target_buffer
    import fetch_pkg::*;
(
    input  logic            clk_g,
    input  logic            rst_i,
    input  logic [PC_W-1:0] lookup_pc_i,
    output logic            hit_o,
    output logic [PC_W-1:0] target_o,
    input  train_t          train_i
);

    logic [TBL_SIZE-1:0] valid_q;
    logic [TAG_W-1:0]    tag_mem    [TBL_SIZE];
    logic [PC_W-1:0]     target_mem [TBL_SIZE];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] rd_tag;
    logic             wr_en;

    // direct mapped, pc[6:2] selects the entry and pc[31:7] is the tag
    assign rd_idx = lookup_pc_i[IDX_W+1:2];
    assign rd_tag = lookup_pc_i[PC_W-1:PC_W-TAG_W];

    assign hit_o    = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign target_o = target_mem[rd_idx];

    // only taken branches allocate
    assign wr_en  = train_i.valid & train_i.taken;
    assign wr_idx = train_i.pc[IDX_W+1:2];

    always_ff @(posedge clk_g) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_g) begin
        if (wr_en) begin
            tag_mem[wr_idx]    <= train_i.pc[PC_W-1:PC_W-TAG_W];
            target_mem[wr_idx] <= train_i.target;
        end
    end

endmodule

/* predictor/gshare_pht.sv */
`timescale 1ns/10ps

module gshare_pht
    import fetch_pkg::*;
(
    input  logic             clk_g,
    input  logic             rst_i,
    input  logic [PC_W-1:0]  lookup_pc_i,
    output logic             taken_o,
    output logic [IDX_W-1:0] index_o,
    input  train_t           train_i,
    input  logic             train_branch_i
);

    // 2-bit saturating counters
    logic [1:0]        ctr_q [TBL_SIZE];
    logic [HIST_W-1:0] hist_q;

    logic [IDX_W-1:0] wr_idx;
    logic [1:0]       wr_ctr;
    logic             do_train;

    // gshare index, pc word bits folded with the global history
    assign index_o = lookup_pc_i[IDX_W+1:2] ^ hist_q;
    assign taken_o = ctr_q[index_o][1];

    // training reuses the index captured at lookup time
    assign do_train = train_i.valid & train_branch_i;
    assign wr_idx   = train_i.index;
    assign wr_ctr   = ctr_q[wr_idx];

    always_ff @(posedge clk_g) begin
        if (rst_i) begin
            // weakly not-taken
            for (int i = 0; i < TBL_SIZE; i++) begin
                ctr_q[i] <= 2'b01;
            end
            hist_q <= '0;
        end else if (do_train) begin
            if (train_i.taken) begin
                if (wr_ctr != 2'b11) begin
                    ctr_q[wr_idx] <= wr_ctr + 2'b01;
                end
            end else begin
                if (wr_ctr != 2'b00) begin
                    ctr_q[wr_idx] <= wr_ctr - 2'b01;
                end
            end
            // history only moves on resolved branches
            hist_q <= {hist_q[HIST_W-2:0], train_i.taken};
        end
    end

endmodule

/* common/fetch_pkg.sv */
package fetch_pkg;

    // address and instruction widths
    localparam int PC_W    = 32;
    localparam int INSTR_W = 32;

    // predictor tables, indexed by pc[6:2]
    localparam int IDX_W    = 5;
    localparam int HIST_W   = 5;
    localparam int TAG_W    = 25;
    localparam int TBL_SIZE = 1 << IDX_W;

    // in-flight predictions, depth must be a power of two
    localparam int RQ_DEPTH = 4;
    localparam int RQ_PTR_W = $clog2(RQ_DEPTH);

    localparam logic [PC_W-1:0] RESET_PC = 32'h0000_0000;

    // one prediction as seen at the start of a bus cycle
    typedef struct packed {
        logic             taken;
        logic [PC_W-1:0]  target;
        logic [IDX_W-1:0] index;
    } pred_t;

    // instruction handed to decode
    typedef struct packed {
        logic [PC_W-1:0]    pc;
        logic [INSTR_W-1:0] instr;
        pred_t              pred;
    } fetch_out_t;

    // outcome reported by execute, oldest first
    typedef struct packed {
        logic            branch;
        logic            taken;
        logic [PC_W-1:0] target;
    } resolve_t;

    // training write to both predictors
    // taken is only set for a resolved branch that was taken
    typedef struct packed {
        logic             valid;
        logic [PC_W-1:0]  pc;
        logic             taken;
        logic [PC_W-1:0]  target;
        logic [IDX_W-1:0] index;
    } train_t;

    typedef struct packed {
        logic            valid;
        logic [PC_W-1:0] pc;
    } redirect_t;

endpackage
